// File: hdl/boardPkg.sv
// board package
// tile, cursor, host port and color types shared by the battleship board core
// tile-state encodings, host port map and the display palette

`default_nettype none

package boardPkg;

    ////////////////////////////////////////////////
    // tiles and cursor
    ////////////////////////////////////////////////
    typedef logic [1:0] tileState_t;        // 2-bit tile contents
    typedef logic [7:0] tileAddr_t;         // {row[3:0], col[3:0]}
    typedef tileAddr_t  cursor_t;
    typedef logic [4:0] shipInfo_t;         // bit 4 orientation, 3..0 length

    localparam tileState_t TileEmpty = 2'd0;
    localparam tileState_t TileShip  = 2'd1;
    localparam tileState_t TileHit   = 2'd2;
    localparam tileState_t TileMiss  = 2'd3;

    localparam int BoardTiles = 16;         // tiles per board side

    ////////////////////////////////////////////////
    // host bus
    ////////////////////////////////////////////////
    typedef logic [7:0] portId_t;
    typedef logic [7:0] portData_t;

    localparam portId_t PortCursor   = 8'd0;
    localparam portId_t PortUsTile   = 8'd1;
    localparam portId_t PortThemTile = 8'd2;
    localparam portId_t PortShipInfo = 8'd3;
    localparam portId_t PortStatus   = 8'd4; // bit 0 = interrupt

    ////////////////////////////////////////////////
    // display
    ////////////////////////////////////////////////
    typedef logic [9:0]  coord_t;           // pixel column / row
    typedef logic [11:0] pixel_t;           // {r, g, b} 4 bits each

    localparam pixel_t ColorEmpty      = 12'h124; // deep water
    localparam pixel_t ColorShip       = 12'h888; // grey hull
    localparam pixel_t ColorHit        = 12'hF20;
    localparam pixel_t ColorMiss       = 12'hEEE;
    localparam pixel_t ColorGhost      = 12'h0F4; // ship being placed
    localparam pixel_t ColorBackground = 12'h000;

endpackage

`default_nettype wire

// File: hdl/tilePortIf.sv
// tile port interface
// one host-side port of a tile RAM: address, write pulse, write data and
// registered read data

`default_nettype none

interface tilePortIf;

    boardPkg::tileAddr_t  addr;         // always the cursor
    logic                 writeEnable;  // one-cycle pulse
    boardPkg::tileState_t writeData;
    boardPkg::tileState_t readData;     // registered in the RAM

    // decoder side
    modport host (output addr, output writeEnable, output writeData, input readData);

    // memory side
    modport ram (input addr, input writeEnable, input writeData, output readData);

endinterface

`default_nettype wire

// File: hdl/hostPortDecoder.sv
// host port decoder
// decodes strobe-bus writes into cursor, ship info and tile writes,
// muxes the read-back data and raises a held tick interrupt

`default_nettype none

module hostPortDecoder #(
    parameter int TickPeriod = 1000     // cycles between ticks
) (
    input  logic                clk,
    input  logic                rst,
    input  boardPkg::portId_t   portId,
    input  boardPkg::portData_t outPort,
    input  logic                writeStrobe,
    input  logic                interruptAck,
    output boardPkg::portData_t inPort,
    output logic                interrupt,
    output boardPkg::cursor_t   cursor,
    output boardPkg::shipInfo_t shipInfo,
    tilePortIf.host             usPort,
    tilePortIf.host             themPort
);

    localparam int CountWidth = $clog2(TickPeriod + 1);
    localparam logic [CountWidth-1:0] TickLast = CountWidth'(TickPeriod - 1);

    logic                  usWrite;     // registered write pulses
    logic                  themWrite;
    boardPkg::tileState_t  tileData;
    logic [CountWidth-1:0] tickCount;

    ////////////////////////////////////////////////
    // host registers
    ////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            cursor    <= '0;
            shipInfo  <= '0;
            usWrite   <= 1'b0;
            themWrite <= 1'b0;
        end else begin
            usWrite   <= writeStrobe && (portId == boardPkg::PortUsTile);
            themWrite <= writeStrobe && (portId == boardPkg::PortThemTile);
            if (writeStrobe && (portId == boardPkg::PortCursor))
                cursor <= outPort;
            if (writeStrobe && (portId == boardPkg::PortShipInfo))
                shipInfo <= outPort[4:0];   // orientation + length
        end
    end

    // tile value rides alongside the pulse
    always_ff @(posedge clk) begin
        if (writeStrobe)
            tileData <= outPort[1:0];
    end

    // both boards addressed by the cursor
    assign usPort.addr          = cursor;
    assign usPort.writeEnable   = usWrite;
    assign usPort.writeData     = tileData;
    assign themPort.addr        = cursor;
    assign themPort.writeEnable = themWrite;
    assign themPort.writeData   = tileData;

    ////////////////////////////////////////////////
    // read mux
    ////////////////////////////////////////////////
    always_comb begin
        case (portId)
            boardPkg::PortCursor:   inPort = cursor;
            boardPkg::PortUsTile:   inPort = {6'b0, usPort.readData};
            boardPkg::PortThemTile: inPort = {6'b0, themPort.readData};
            boardPkg::PortShipInfo: inPort = {3'b0, shipInfo};
            boardPkg::PortStatus:   inPort = {7'b0, interrupt};
            default:                inPort = '0;  // unmapped
        endcase
    end

    ////////////////////////////////////////////////
    // tick interrupt
    ////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            tickCount <= '0;
            interrupt <= 1'b0;
        end else begin
            tickCount <= (tickCount == TickLast) ? '0 : tickCount + 1'b1;
            if (interruptAck)
                interrupt <= 1'b0;      // ack wins over a same-cycle tick
            else if (tickCount == TickLast)
                interrupt <= 1'b1;      // held until acknowledged
        end
    end

endmodule

`default_nettype wire

// File: hdl/tileRam.sv
// tile RAM
// 256 x 2-bit board memory, registered host read/write port and an
// independent registered read port for the raster scan

`default_nettype none

module tileRam (
    input  logic                 clk,
    tilePortIf.ram               hostPort,
    input  boardPkg::tileAddr_t  scanAddr,
    output boardPkg::tileState_t scanData
);

    localparam int TileCount = boardPkg::BoardTiles * boardPkg::BoardTiles;

    boardPkg::tileState_t mem [0:TileCount-1];
    boardPkg::tileState_t hostRead;

    // host port, read-first
    always_ff @(posedge clk) begin
        if (hostPort.writeEnable)
            mem[hostPort.addr] <= hostPort.writeData;
        hostRead <= mem[hostPort.addr];
    end

    assign hostPort.readData = hostRead;

    // scan port, one cycle latency
    always_ff @(posedge clk) begin
        scanData <= mem[scanAddr];
    end

endmodule

`default_nettype wire

// File: hdl/scanTiming.sv
// scan timing
// free-running column and row counters for the raster, one pixel per clock
// decodes visible area and active-low sync pulses from the counter windows

`default_nettype none

module scanTiming #(
    parameter int HVisible = 640,
    parameter int HFront   = 16,
    parameter int HSync    = 96,
    parameter int HBack    = 48,
    parameter int VVisible = 480,
    parameter int VFront   = 10,
    parameter int VSync    = 2,
    parameter int VBack    = 33
) (
    input  logic             clk,
    input  logic             rst,
    output boardPkg::coord_t pixelX,
    output boardPkg::coord_t pixelY,
    output logic             visible,
    output logic             hsync,
    output logic             vsync
);

    localparam int HTotal     = HVisible + HFront + HSync + HBack;
    localparam int VTotal     = VVisible + VFront + VSync + VBack;
    localparam int HSyncStart = HVisible + HFront;
    localparam int VSyncStart = VVisible + VFront;

    boardPkg::coord_t hCount;
    boardPkg::coord_t vCount;

    ////////////////////////////////////////////////
    // counters
    ////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            hCount <= '0;
            vCount <= '0;
        end else if (hCount == boardPkg::coord_t'(HTotal - 1)) begin
            hCount <= '0;                               // end of line
            vCount <= (vCount == boardPkg::coord_t'(VTotal - 1)) ? '0 : vCount + 1'b1;
        end else begin
            hCount <= hCount + 1'b1;
        end
    end

    // window decode
    assign pixelX  = hCount;
    assign pixelY  = vCount;
    assign visible = (hCount < boardPkg::coord_t'(HVisible))
                  && (vCount < boardPkg::coord_t'(VVisible));
    assign hsync   = !((hCount >= boardPkg::coord_t'(HSyncStart))
                    && (hCount < boardPkg::coord_t'(HSyncStart + HSync)));  // active low
    assign vsync   = !((vCount >= boardPkg::coord_t'(VSyncStart))
                    && (vCount < boardPkg::coord_t'(VSyncStart + VSync)));

endmodule

`default_nettype wire

// File: hdl/boardRenderer.sv
// board renderer
// maps each pixel to a tile of the own or opponent board, fetches its state,
// overlays the ghost ship and registers color and syncs two cycles later

`default_nettype none

module boardRenderer #(
    parameter int TilePixShift = 4      // tile is 2^n pixels square
) (
    input  logic                 clk,
    input  logic                 rst,
    input  boardPkg::coord_t     pixelX,
    input  boardPkg::coord_t     pixelY,
    input  logic                 visible,
    input  logic                 hsyncIn,
    input  logic                 vsyncIn,
    input  boardPkg::cursor_t    cursor,
    input  boardPkg::shipInfo_t  shipInfo,
    input  boardPkg::tileState_t usScanData,
    input  boardPkg::tileState_t themScanData,
    output boardPkg::tileAddr_t  usScanAddr,
    output boardPkg::tileAddr_t  themScanAddr,
    output logic                 hsync,
    output logic                 vsync,
    output boardPkg::pixel_t     color
);

    localparam boardPkg::coord_t BoardPix = boardPkg::coord_t'(boardPkg::BoardTiles << TilePixShift);
    localparam boardPkg::coord_t BothPix  = boardPkg::coord_t'(2 * BoardPix);

    boardPkg::coord_t usX, themX, tileY; // pixel >> shift
    logic [3:0] tileRow, usCol, themCol;
    logic       inUs, inThem, ghost;
    logic [4:0] ghostEndCol, ghostEndRow;   // 5 bits, so no wrap past the edge
    logic       inUsQ, inThemQ, ghostQ, hsyncQ, vsyncQ;

    function automatic boardPkg::pixel_t tileColor(input boardPkg::tileState_t state);
        case (state)
            boardPkg::TileShip: return boardPkg::ColorShip;
            boardPkg::TileHit:  return boardPkg::ColorHit;
            boardPkg::TileMiss: return boardPkg::ColorMiss;
            default:            return boardPkg::ColorEmpty;
        endcase
    endfunction

    ////////////////////////////////////////////////
    // stage 0: tile lookup
    ////////////////////////////////////////////////
    assign usX     = pixelX >> TilePixShift;
    assign themX   = (pixelX - BoardPix) >> TilePixShift; // opponent board origin
    assign tileY   = pixelY >> TilePixShift;
    assign tileRow = tileY[3:0];
    assign usCol   = usX[3:0];
    assign themCol = themX[3:0];

    assign usScanAddr   = {tileRow, usCol};
    assign themScanAddr = {tileRow, themCol};

    assign inUs   = visible && (pixelX < BoardPix) && (pixelY < BoardPix);
    assign inThem = visible && (pixelX >= BoardPix) && (pixelX < BothPix)
                 && (pixelY < BoardPix);

    // ghost ship runs from the cursor for length tiles
    assign ghostEndCol = {1'b0, cursor[3:0]} + {1'b0, shipInfo[3:0]};
    assign ghostEndRow = {1'b0, cursor[7:4]} + {1'b0, shipInfo[3:0]};
    assign ghost = inUs && (shipInfo[4]
        ? (usCol == cursor[3:0]) && (tileRow >= cursor[7:4]) && ({1'b0, tileRow} < ghostEndRow)
        : (tileRow == cursor[7:4]) && (usCol >= cursor[3:0]) && ({1'b0, usCol} < ghostEndCol));

    ////////////////////////////////////////////////
    // stage 1 / 2: wait for RAM, then color
    ////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            {inUsQ, inThemQ, ghostQ} <= '0;
            hsyncQ <= 1'b1;                 // syncs idle high
            vsyncQ <= 1'b1;
            hsync  <= 1'b1;
            vsync  <= 1'b1;
            color  <= boardPkg::ColorBackground;
        end else begin
            inUsQ   <= inUs;
            inThemQ <= inThem;
            ghostQ  <= ghost;
            hsyncQ  <= hsyncIn;
            vsyncQ  <= vsyncIn;
            hsync   <= hsyncQ;               // stays paired with its color
            vsync   <= vsyncQ;
            if (ghostQ)
                color <= boardPkg::ColorGhost;
            else if (inUsQ)
                color <= tileColor(usScanData);
            else if (inThemQ)
                color <= tileColor(themScanData);
            else
                color <= boardPkg::ColorBackground;
        end
    end

endmodule

`default_nettype wire

// File: hdl/battleshipBoard.sv
// battleship board core
// host port decoder, own and opponent tile RAMs, raster timing and the
// board renderer, all on one clock

`default_nettype none

module battleshipBoard #(
    parameter int HVisible     = 640,
    parameter int HFront       = 16,
    parameter int HSync        = 96,
    parameter int HBack        = 48,
    parameter int VVisible     = 480,
    parameter int VFront       = 10,
    parameter int VSync        = 2,
    parameter int VBack        = 33,
    parameter int TilePixShift = 4,
    parameter int TickPeriod   = 1000000
) (
    input  logic                clk,
    input  logic                rst,
    input  boardPkg::portId_t   portId,
    input  boardPkg::portData_t outPort,
    input  logic                writeStrobe,
    input  logic                interruptAck,
    output boardPkg::portData_t inPort,
    output logic                interrupt,
    output logic                hsync,
    output logic                vsync,
    output boardPkg::pixel_t    color
);

    boardPkg::cursor_t    cursor;
    boardPkg::shipInfo_t  shipInfo;
    boardPkg::coord_t     pixelX, pixelY;
    logic                 visible, rawHsync, rawVsync; // undelayed scan outputs
    boardPkg::tileAddr_t  usScanAddr, themScanAddr;
    boardPkg::tileState_t usScanData, themScanData;

    tilePortIf usPort ();
    tilePortIf themPort ();

    ////////////////////////////////////////////////
    // host side
    ////////////////////////////////////////////////
    hostPortDecoder #(.TickPeriod(TickPeriod)) decoder_i (
        .clk(clk), .rst(rst), .portId(portId), .outPort(outPort),
        .writeStrobe(writeStrobe), .interruptAck(interruptAck), .inPort(inPort),
        .interrupt(interrupt), .cursor(cursor), .shipInfo(shipInfo),
        .usPort(usPort.host), .themPort(themPort.host)
    );

    tileRam usRam (.clk(clk), .hostPort(usPort.ram),
                   .scanAddr(usScanAddr), .scanData(usScanData));
    tileRam themRam (.clk(clk), .hostPort(themPort.ram),
                     .scanAddr(themScanAddr), .scanData(themScanData));

    ////////////////////////////////////////////////
    // video side
    ////////////////////////////////////////////////
    scanTiming #(
        .HVisible(HVisible), .HFront(HFront), .HSync(HSync), .HBack(HBack),
        .VVisible(VVisible), .VFront(VFront), .VSync(VSync), .VBack(VBack)
    ) scan_i (
        .clk(clk), .rst(rst), .pixelX(pixelX), .pixelY(pixelY),
        .visible(visible), .hsync(rawHsync), .vsync(rawVsync)
    );

    boardRenderer #(.TilePixShift(TilePixShift)) renderer_i (
        .clk(clk), .rst(rst), .pixelX(pixelX), .pixelY(pixelY), .visible(visible),
        .hsyncIn(rawHsync), .vsyncIn(rawVsync), .cursor(cursor), .shipInfo(shipInfo),
        .usScanData(usScanData), .themScanData(themScanData),
        .usScanAddr(usScanAddr), .themScanAddr(themScanAddr),
        .hsync(hsync), .vsync(vsync), .color(color)
    );

endmodule

`default_nettype wire

// File: tests/battleshipBoardTb.sv
// battleship board testbench
// acts as the host on the strobe bus from a command file and checks
// read-back, the tick interrupt, per-frame color counts and the syncs

`default_nettype none

module battleshipBoardTb;

    localparam int TickPeriod  = 40;
    localparam int HVisible    = 72;
    localparam int HFront      = 2;
    localparam int HSyncLen    = 4;
    localparam int HBack       = 2;
    localparam int VVisible    = 36;
    localparam int VFront      = 1;
    localparam int VSyncLen    = 2;
    localparam int VBack       = 1;
    localparam int HTotal      = HVisible + HFront + HSyncLen + HBack;
    localparam int VTotal      = VVisible + VFront + VSyncLen + VBack;
    localparam int FrameCycles = HTotal * VTotal;
    localparam int FrameLimit  = 2 * FrameCycles;

    logic                clk;
    logic                rst;
    boardPkg::portId_t   portId;
    boardPkg::portData_t outPort;
    logic                writeStrobe;
    logic                interruptAck;
    boardPkg::portData_t inPort;
    logic                interrupt;
    logic                hsync;
    logic                vsync;
    boardPkg::pixel_t    color;

    int errors   = 0;
    int checks   = 0;
    int nextTick = TickPeriod;  // expected rise edge of the next tick
    int edgeCount;              // rising edges since reset release

    battleshipBoard #(
        .HVisible(HVisible), .HFront(HFront), .HSync(HSyncLen), .HBack(HBack),
        .VVisible(VVisible), .VFront(VFront), .VSync(VSyncLen), .VBack(VBack),
        .TilePixShift(1), .TickPeriod(TickPeriod)
    ) battleshipBoard_i (
        .clk(clk), .rst(rst), .portId(portId), .outPort(outPort),
        .writeStrobe(writeStrobe), .interruptAck(interruptAck), .inPort(inPort),
        .interrupt(interrupt), .hsync(hsync), .vsync(vsync), .color(color)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        if (rst)
            edgeCount <= 0;
        else
            edgeCount <= edgeCount + 1;
    end

    //////////////////////////////////////////////////
    // host bus helpers
    //////////////////////////////////////////////////
    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic writePort(input logic [7:0] id, input logic [7:0] data);
        @(negedge clk);
        portId      = id;
        outPort     = data;
        writeStrobe = 1'b1;     // one strobe cycle
        @(negedge clk);
        writeStrobe = 1'b0;
    endtask

    task automatic readPort(input logic [7:0] id, input logic [7:0] expected);
        @(negedge clk);
        portId = id;
        repeat (2) @(negedge clk);  // tile read-back is two edges behind
        checkValue($sformatf("inPort[%0d]", id), 32'(inPort), 32'(expected));
    endtask

    // mixes the low and high halves of row and column
    function automatic logic [1:0] fillState(input logic [7:0] addr, input logic [1:0] seed);
        logic [3:0] lowProd;
        logic [3:0] highProd;
        lowProd  = {2'b0, addr[5:4]} * {2'b0, addr[1:0]};
        highProd = {2'b0, addr[7:6]} * {2'b0, addr[3:2]};
        return lowProd[1:0] + highProd[1:0] + seed;
    endfunction

    task automatic fillBoard(input logic [7:0] id, input logic [1:0] seed);
        for (int addr = 0; addr < 256; addr++) begin
            writePort(boardPkg::PortCursor, 8'(addr));
            writePort(id, {6'b0, fillState(8'(addr), seed)});
        end
    endtask

    //////////////////////////////////////////////////
    // interrupt and frame checks
    //////////////////////////////////////////////////
    task automatic serviceTick();
        int waited;
        waited = 0;
        while (!interrupt && waited < 2 * TickPeriod) begin
            @(negedge clk);
            waited++;
        end
        if (!interrupt) begin
            errors++;
            $display("Timeout: interrupt did not rise within %0d cycles", 2 * TickPeriod);
        end else begin
            checkValue("interrupt rise edge", 32'(edgeCount), 32'(nextTick));
            repeat (3) @(negedge clk);
            checkValue("interrupt", 32'(interrupt), 32'd1);     // held, no ack yet
            readPort(boardPkg::PortStatus, 8'h01);
            interruptAck = 1'b1;
            @(negedge clk);
            interruptAck = 1'b0;
            checkValue("interrupt", 32'(interrupt), 32'd0);
            readPort(boardPkg::PortStatus, 8'h00);
            nextTick += TickPeriod;
        end
    endtask

    task automatic countFrame(input boardPkg::pixel_t target, input int expected);
        int   waited;
        int   count;
        int   hsyncLow;
        int   vsyncLow;
        int   firstHsync;
        int   firstLit;
        logic lastV;
        logic fell;
        waited     = 0;
        count      = 0;
        hsyncLow   = 0;
        vsyncLow   = 0;
        firstHsync = -1;
        firstLit   = -1;
        lastV      = vsync;
        do begin                            // find the frame start
            @(negedge clk);
            fell  = lastV && !vsync;
            lastV = vsync;
            waited++;
        end while (!fell && waited < FrameLimit);
        if (!fell) begin
            errors++;
            $display("Timeout: no vsync falling edge to start the frame count");
        end else begin
            waited = 0;
            do begin                        // one full frame of output cycles
                if (color == target)
                    count++;
                if (color != boardPkg::ColorBackground && firstLit < 0)
                    firstLit = waited;      // top-left tile of the own board
                if (!hsync) begin
                    hsyncLow++;
                    if (firstHsync < 0)
                        firstHsync = waited;
                end
                if (!vsync)
                    vsyncLow++;
                @(negedge clk);
                fell  = lastV && !vsync;
                lastV = vsync;
                waited++;
            end while (!fell && waited < FrameLimit);
            if (!fell) begin
                errors++;
                $display("Timeout: no vsync falling edge to end the frame count");
            end else begin
                checkValue($sformatf("pixels of color %03h", target), 32'(count),
                           32'(expected));
                checkValue("hsync low cycles", 32'(hsyncLow), 32'(HSyncLen * VTotal));
                checkValue("vsync low cycles", 32'(vsyncLow), 32'(VSyncLen * HTotal));
                // frame starts at the first vsync line, column 0
                checkValue("first hsync low cycle", 32'(firstHsync),
                           32'(HVisible + HFront));
                checkValue("first board pixel cycle", 32'(firstLit),
                           32'((VTotal - VVisible - VFront) * HTotal));
            end
        end
    endtask

    //////////////////////////////////////////////////
    // command file
    //////////////////////////////////////////////////
    initial begin
        int          fd;
        string       line;
        string       cmd;
        logic [31:0] argA;
        logic [31:0] argB;
        rst          = 1'b1;
        portId       = '0;
        outPort      = '0;
        writeStrobe  = 1'b0;
        interruptAck = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        checkValue("interrupt", 32'(interrupt), 32'd0);     // reset state
        fd = $fopen("tests/boardStim.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the command file tests/boardStim.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.substr(0, 0) != "#") begin
                    void'($sscanf(line, "%s %h %h", cmd, argA, argB));
                    if (cmd == "write")
                        writePort(argA[7:0], argB[7:0]);
                    else if (cmd == "read")
                        readPort(argA[7:0], argB[7:0]);
                    else if (cmd == "fill")
                        fillBoard(argA[7:0], argB[1:0]);
                    else if (cmd == "tick")
                        serviceTick();
                    else if (cmd == "frame") begin
                        void'($sscanf(line, "%s %h %d", cmd, argA, argB));  // decimal count
                        countFrame(argA[11:0], int'(argB));
                    end else begin
                        errors++;
                        $display("unknown command in the command file: %s", cmd);
                    end
                end
            end
            $fclose(fd);
        end
        repeat (4) @(negedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: battleshipBoard.f
hdl/boardPkg.sv
hdl/tilePortIf.sv
hdl/hostPortDecoder.sv
hdl/tileRam.sv
hdl/scanTiming.sv
hdl/boardRenderer.sv
hdl/battleshipBoard.sv
tests/battleshipBoardTb.sv

// File: Makefile
# Verilator flow for the battleship board core

VERILATOR ?= verilator
TOP       := battleshipBoardTb
RTL_TOP   := battleshipBoard
FILELIST  := battleshipBoard.f
OBJDIR    := obj_dir
LOG       := sim.log
FLAGS     := --timing --Mdir $(OBJDIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	! grep -q "Test failed" $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: tests/boardStim.txt
# command  argA(hex)  argB (hex, frame count decimal)
# write port value | read port expected | fill port seed | frame color count | tick
read  00 00
read  03 00
read  04 00
tick
tick
fill  01 0
fill  02 3
write 00 00
write 01 02
read  01 02
read  02 03
write 02 01
read  02 01
read  01 02
write 00 35
read  00 35
write 01 01
write 02 00
read  01 01
read  02 00
frame 888 488
frame f20 480
frame eee 536
frame 124 544
frame 000 1152
write 00 02
write 03 04
read  03 04
frame 0f4 16
frame 124 528
write 00 e3
write 03 14
frame 0f4 8
frame f20 476
frame 888 484
